// File: src/cpuPkg.sv
/*
  CPU package for the 16-bit execute core
  Holds the core widths, credit counts, opcode encoding and the
  instruction, decoded-instruction and result record types
*/
`default_nettype none

package cpuPkg;

  //////////////////////////////////////////////////////////////////////
  // Widths and credit counts
  //////////////////////////////////////////////////////////////////////
  localparam int dataWidth    = 16;  // Data word width
  localparam int regAddrWidth = 4;   // Register index width
  localparam int numRegs      = 16;  // Register file depth
  localparam int inCredits    = 4;   // Instruction buffer depth = source credits
  localparam int outCredits   = 2;   // Result slots granted by the sink after reset

  //////////////////////////////////////////////////////////////////////
  // Opcodes
  //////////////////////////////////////////////////////////////////////
  // Codes 10 to 14 are undefined and decode to opNop
  typedef enum logic [3:0] {
    opAdd = 4'h0,  // rd = rs + rt
    opSub = 4'h1,  // rd = rs - rt
    opAnd = 4'h2,  // Bitwise and
    opOr  = 4'h3,  // Bitwise or
    opXor = 4'h4,  // Bitwise xor
    opSll = 4'h5,  // Shift left logical by shamt
    opSrl = 4'h6,  // Shift right logical by shamt
    opSra = 4'h7,  // Shift right arithmetic by shamt
    opLlb = 4'h8,  // Load low byte of rd
    opLhb = 4'h9,  // Load high byte of rd
    opNop = 4'hF   // No write
  } opcodeE;

  //////////////////////////////////////////////////////////////////////
  // Instruction and result records
  //////////////////////////////////////////////////////////////////////
  // Raw word as it arrives; the byte immediate spans rs and rt
  typedef struct packed {
    logic [3:0]              opcode;  // Bits 15:12
    logic [regAddrWidth-1:0] rd;      // Bits 11:8
    logic [regAddrWidth-1:0] rs;      // Bits 7:4
    logic [regAddrWidth-1:0] rt;      // Bits 3:0, also shift amount
  } instrWordT;

  // Decoder output, held for one cycle in the execute stage
  typedef struct packed {
    opcodeE                  op;       // Operation to run
    logic [regAddrWidth-1:0] dstReg;   // Destination register
    logic [regAddrWidth-1:0] srcReg1;  // First read port, rd for byte loads
    logic [regAddrWidth-1:0] srcReg2;  // Second read port
    logic [3:0]              shamt;    // Shift amount
    logic [7:0]              imm8;     // Byte immediate
    logic                    writeEn;  // Clear for opNop or rd of 0
  } decodedInstrT;

  // Record sent out on the result channel
  typedef struct packed {
    logic [regAddrWidth-1:0] dstReg;  // Destination register
    logic [dataWidth-1:0]    value;   // ALU result
    logic                    zero;    // Value is zero
    logic                    neg;     // Value sign bit
    logic                    wrote;   // Register file was written
  } resultT;

endpackage

`default_nettype wire

// File: src/instrDecoder.sv
/*
  Instruction decoder
  Splits a raw instruction word into its fields, maps the opcode and
  works out the read ports and the write enable. Purely combinational
*/
`default_nettype none

module instrDecoder (
  input  cpuPkg::instrWordT    issueWord,  // Word popped from the buffer
  output cpuPkg::decodedInstrT decoded     // Fields ready for register read
);
  import cpuPkg::*;

  opcodeE op;      // Mapped opcode
  logic   isLoad;  // Byte load, merges into the old rd value

  //////////////////////////////////////////////////////////////////////
  // Opcode mapping
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    unique case (issueWord.opcode)
      4'h0:    op = opAdd;
      4'h1:    op = opSub;
      4'h2:    op = opAnd;
      4'h3:    op = opOr;
      4'h4:    op = opXor;
      4'h5:    op = opSll;
      4'h6:    op = opSrl;
      4'h7:    op = opSra;
      4'h8:    op = opLlb;
      4'h9:    op = opLhb;
      default: op = opNop;  // Undefined codes do nothing
    endcase
  end

  assign isLoad = (op == opLlb) || (op == opLhb);

  //////////////////////////////////////////////////////////////////////
  // Field extraction
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    decoded.op      = op;
    decoded.dstReg  = issueWord.rd;
    // Byte loads read rd so the other byte can be kept
    decoded.srcReg1 = isLoad ? issueWord.rd : issueWord.rs;
    decoded.srcReg2 = issueWord.rt;              // Unused by shifts and loads
    decoded.shamt   = issueWord.rt;              // Low nibble is the shift amount
    decoded.imm8    = {issueWord.rs, issueWord.rt};
    // No write for opNop or for the hardwired zero register
    decoded.writeEn = (op != opNop) && (issueWord.rd != '0);
  end

endmodule

`default_nettype wire

// File: src/registerFile.sv
/*
  Register file, 16 x 16 bits
  Two synchronous read ports and one synchronous write port. A write
  on the same edge as a read of that register is passed to the read
  register. Register 0 always reads zero
*/
`default_nettype none

module registerFile (
  input  logic                            clk,
  input  logic                            rst,
  input  logic [cpuPkg::regAddrWidth-1:0] srcReg1,    // Read address, port 1
  input  logic [cpuPkg::regAddrWidth-1:0] srcReg2,    // Read address, port 2
  output logic [cpuPkg::dataWidth-1:0]    readData1,  // Registered read data, port 1
  output logic [cpuPkg::dataWidth-1:0]    readData2,  // Registered read data, port 2
  input  logic                            wrEn,       // Write strobe
  input  logic [cpuPkg::regAddrWidth-1:0] wrAddr,     // Write address
  input  logic [cpuPkg::dataWidth-1:0]    wrData      // Write data
);
  import cpuPkg::*;

  logic [dataWidth-1:0] regs [numRegs];  // Storage array
  logic                 wrLive;          // Write that actually lands
  logic [dataWidth-1:0] rdNext1;         // Read port 1 next value
  logic [dataWidth-1:0] rdNext2;         // Read port 2 next value

  assign wrLive = wrEn && (wrAddr != '0);  // r0 is never written

  //////////////////////////////////////////////////////////////////////
  // Read path with write-first bypass
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    if (srcReg1 == '0) rdNext1 = '0;                              // Hardwired zero
    else if (wrLive && (wrAddr == srcReg1)) rdNext1 = wrData;     // Bypass
    else rdNext1 = regs[srcReg1];
    if (srcReg2 == '0) rdNext2 = '0;
    else if (wrLive && (wrAddr == srcReg2)) rdNext2 = wrData;
    else rdNext2 = regs[srcReg2];
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      readData1 <= '0;
      readData2 <= '0;
    end else begin
      readData1 <= rdNext1;
      readData2 <= rdNext2;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Write path
  //////////////////////////////////////////////////////////////////////
  // All registers come up zero after reset
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < numRegs; i++) begin
        regs[i] <= '0;
      end
    end else if (wrLive) begin
      regs[wrAddr] <= wrData;
    end
  end

endmodule

`default_nettype wire

// File: src/aluUnit.sv
/*
  ALU, single cycle
  Add, subtract, bitwise logic, shifts by shamt and the two byte loads.
  Builds the result record with zero and negative flags
*/
`default_nettype none

module aluUnit (
  input  logic                         valid,      // Execute stage holds an instruction
  input  cpuPkg::decodedInstrT         instrIn,    // Decoded instruction
  input  logic [cpuPkg::dataWidth-1:0] operandA,   // Read port 1 data
  input  logic [cpuPkg::dataWidth-1:0] operandB,   // Read port 2 data
  output cpuPkg::resultT               resultOut   // Result record
);
  import cpuPkg::*;

  logic [dataWidth-1:0] value;  // Operation result

  //////////////////////////////////////////////////////////////////////
  // Operation select
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    unique case (instrIn.op)
      opAdd: begin
        value = operandA + operandB;   // Wraps at 16 bits
      end
      opSub: begin
        value = operandA - operandB;   // Wraps at 16 bits
      end
      opAnd: begin
        value = operandA & operandB;
      end
      opOr: begin
        value = operandA | operandB;
      end
      opXor: begin
        value = operandA ^ operandB;
      end
      opSll: begin
        value = operandA << instrIn.shamt;
      end
      opSrl: begin
        value = operandA >> instrIn.shamt;  // Zero fill
      end
      opSra: begin
        value = $signed(operandA) >>> instrIn.shamt;  // Sign fill
      end
      opLlb: begin
        value = {operandA[dataWidth-1:8], instrIn.imm8};  // Keep upper byte of rd
      end
      opLhb: begin
        value = {instrIn.imm8, operandA[7:0]};  // Keep lower byte of rd
      end
      default: begin
        value = '0;  // opNop
      end
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Result record
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    resultOut.dstReg = instrIn.dstReg;
    resultOut.value  = value;
    resultOut.zero   = (value == '0);
    resultOut.neg    = value[dataWidth-1];        // Sign bit
    // Bubble cycles never write
    resultOut.wrote  = valid && instrIn.writeEn;
  end

endmodule

`default_nettype wire

// File: src/issueControl.sv
/*
  Issue control
  Buffers incoming instructions in a small circular queue, returns an
  input credit on every pop and tracks the output credits. Issues the
  head word whenever the queue holds one and a result slot is free
*/
`default_nettype none

module issueControl (
  input  logic              clk,
  input  logic              rst,
  input  logic              instrValid,    // Source pushes a word
  input  cpuPkg::instrWordT instr,         // Pushed word
  output logic              instrCredit,   // One pulse per popped word
  input  logic              resultCredit,  // Sink frees one result slot
  output logic              issueFire,     // Head word issues this cycle
  output cpuPkg::instrWordT issueWord      // Head of the queue
);
  import cpuPkg::*;

  typedef logic [$clog2(inCredits)-1:0]    ptrT;     // Queue index
  typedef logic [$clog2(inCredits+1)-1:0]  fillT;    // Queue occupancy
  typedef logic [$clog2(outCredits+1)-1:0] creditT;  // Output credit count

  instrWordT instrBuf [inCredits];  // Queue storage
  ptrT       wrPtr;                 // Next free slot
  ptrT       rdPtr;                 // Head slot
  fillT      bufCount;              // Words held
  creditT    outCreditCnt;          // Result slots still free
  logic      bufEmpty;

  // Step a pointer around the ring
  function automatic ptrT nextPtr(input ptrT ptr);
    return (ptr == ptrT'(inCredits - 1)) ? '0 : ptr + 1'b1;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Issue decision
  //////////////////////////////////////////////////////////////////////
  assign bufEmpty  = (bufCount == '0);
  assign issueFire = !bufEmpty && (outCreditCnt != '0);  // Word ready and slot free
  assign issueWord = instrBuf[rdPtr];

  //////////////////////////////////////////////////////////////////////
  // Instruction queue
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (instrValid) begin
      instrBuf[wrPtr] <= instr;  // Source only pushes while it has a credit
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wrPtr    <= '0;
      rdPtr    <= '0;
      bufCount <= '0;
    end else begin
      if (instrValid) wrPtr <= nextPtr(wrPtr);
      if (issueFire) rdPtr <= nextPtr(rdPtr);
      unique case ({instrValid, issueFire})
        2'b10:   bufCount <= bufCount + 1'b1;  // Push only
        2'b01:   bufCount <= bufCount - 1'b1;  // Pop only
        default: bufCount <= bufCount;         // Both or neither
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Credits
  //////////////////////////////////////////////////////////////////////
  // Output slot is taken at issue, so at most outCredits results in flight
  always_ff @(posedge clk) begin
    if (rst) begin
      outCreditCnt <= creditT'(outCredits);
      instrCredit  <= 1'b0;
    end else begin
      instrCredit <= issueFire;  // Queue slot handed back to the source
      unique case ({resultCredit, issueFire})
        2'b10:   outCreditCnt <= outCreditCnt + 1'b1;  // Slot returned
        2'b01:   outCreditCnt <= outCreditCnt - 1'b1;  // Slot taken
        default: outCreditCnt <= outCreditCnt;         // Cancel out
      endcase
    end
  end

endmodule

`default_nettype wire

// File: src/execCore.sv
/*
  Execute core top level
  Queue and issue, decode with register read, one-cycle ALU, then the
  result register. Results leave two cycles after issue
*/
`default_nettype none

module execCore (
  input  logic              clk,
  input  logic              rst,
  input  logic              instrValid,    // Instruction channel strobe
  input  cpuPkg::instrWordT instr,         // Raw instruction word
  output logic              instrCredit,   // Credit back to the source
  output logic              resultValid,   // Result channel strobe
  output cpuPkg::resultT    result,        // Result record
  input  logic              resultCredit   // Credit back from the sink
);
  import cpuPkg::*;

  logic                    issueFire;   // Head word leaves the queue
  instrWordT               issueWord;   // Word being issued
  decodedInstrT            decoded;     // Decoder output, issue cycle
  logic                    execValid;   // Execute stage occupied
  decodedInstrT            execInstr;   // Execute stage payload
  logic [dataWidth-1:0]    readData1;
  logic [dataWidth-1:0]    readData2;
  resultT                  aluResult;   // Next value of the result register
  logic                    wrEn;
  logic [regAddrWidth-1:0] wrAddr;
  logic [dataWidth-1:0]    wrData;

  //////////////////////////////////////////////////////////////////////
  // Issue, decode and register read
  //////////////////////////////////////////////////////////////////////
  issueControl uIssue (
    .clk(clk), .rst(rst),
    .instrValid(instrValid), .instr(instr), .instrCredit(instrCredit),
    .resultCredit(resultCredit), .issueFire(issueFire), .issueWord(issueWord)
  );

  instrDecoder uDecode (.issueWord(issueWord), .decoded(decoded));

  registerFile uRegs (
    .clk(clk), .rst(rst),
    .srcReg1(decoded.srcReg1), .srcReg2(decoded.srcReg2),
    .readData1(readData1), .readData2(readData2),
    .wrEn(wrEn), .wrAddr(wrAddr), .wrData(wrData)
  );

  // Execute stage lines up with the registered read data
  always_ff @(posedge clk) begin
    if (rst) execValid <= 1'b0;
    else execValid <= issueFire;
  end

  always_ff @(posedge clk) begin
    if (issueFire) execInstr <= decoded;
  end

  //////////////////////////////////////////////////////////////////////
  // Execute and result
  //////////////////////////////////////////////////////////////////////
  aluUnit uAlu (
    .valid(execValid), .instrIn(execInstr),
    .operandA(readData1), .operandB(readData2), .resultOut(aluResult)
  );

  // Write lands on the edge that loads the result register, so the
  // next issued word reads it through the bypass
  assign wrEn   = aluResult.wrote;
  assign wrAddr = aluResult.dstReg;
  assign wrData = aluResult.value;

  always_ff @(posedge clk) begin
    if (rst) resultValid <= 1'b0;
    else resultValid <= execValid;  // One pulse per instruction
  end

  always_ff @(posedge clk) begin
    if (execValid) result <= aluResult;
  end

endmodule

`default_nettype wire

// File: verif/execCore_chk.sv
/*
  Assertion checker for the execute core
  Output credit range, queue overflow and the hardwired r0 rule
*/
`default_nettype none

module execCoreChk (
  input logic                                    clk,
  input logic                                    rst,
  input logic                                    instrValid,
  input logic                                    issueFire,
  input logic                                    resultCredit,
  input logic [$clog2(cpuPkg::outCredits+1)-1:0] outCreditCnt,
  input logic [$clog2(cpuPkg::inCredits+1)-1:0]  bufCount,
  input logic                                    resultValid,
  input cpuPkg::resultT                          result
);
  timeunit 1ns;
  timeprecision 100ps;
  import cpuPkg::*;

  //////////////////////////////////////////////////////////////////////
  // Output credits
  //////////////////////////////////////////////////////////////////////
  creditCeiling: assert property (@(posedge clk) disable iff (rst)
    outCreditCnt <= outCredits) else $error("Output credit count above its grant");
  // An empty counter only moves up on a returned slot
  creditFloor: assert property (@(posedge clk) disable iff (rst)
    ((outCreditCnt == '0) && !resultCredit) |=> (outCreditCnt == '0))
    else $error("Output credit count decremented below zero");
  creditReturn: assert property (@(posedge clk) disable iff (rst)
    (resultCredit && !issueFire) |-> (outCreditCnt < outCredits))
    else $error("Sink returned a credit it never had");

  //////////////////////////////////////////////////////////////////////
  // Queue and r0
  //////////////////////////////////////////////////////////////////////
  bufCeiling: assert property (@(posedge clk) disable iff (rst)
    (instrValid && !issueFire) |-> (bufCount < inCredits))
    else $error("Instruction queue overflow");
  zeroReg: assert property (@(posedge clk) disable iff (rst)
    (resultValid && (result.dstReg == '0)) |-> !result.wrote)
    else $error("Result for r0 reports a write");

endmodule

bind execCore execCoreChk uChk (
  .clk(clk), .rst(rst), .instrValid(instrValid), .issueFire(issueFire),
  .resultCredit(resultCredit), .outCreditCnt(uIssue.outCreditCnt),
  .bufCount(uIssue.bufCount), .resultValid(resultValid), .result(result)
);

`default_nettype wire

// File: verif/execCoreTb.sv
/*
  Testbench for the execute core
  Credit-aware source and sink, a register-level reference model and
  directed tests for the ALU ops, bypass, r0, back-pressure and nops
*/
`default_nettype none

module execCoreTb;
  timeunit 1ns;
  timeprecision 100ps;
  import cpuPkg::*;

  localparam int timeoutCycles = 200;  // Limit for every wait loop

  logic      clk;
  logic      rst;
  logic      instrValid;
  instrWordT instr;
  logic      instrCredit;
  logic      resultValid;
  resultT    result;
  logic      resultCredit;

  logic [dataWidth-1:0] refRegs [numRegs];  // Model register state
  resultT               expQ [$];           // Expected results, issue order
  int                   srcCredits;         // Credits the source holds
  int                   heldCredits;        // Result slots the sink still owes
  int                   resultCount;        // Results seen so far
  logic                 sinkOpen;           // Sink hands credits back when set
  logic                 giveCredit;
  logic [15:0]          lfsrState;
  string                testName;

  execCore i_dut (
    .clk(clk), .rst(rst), .instrValid(instrValid), .instr(instr),
    .instrCredit(instrCredit), .resultValid(resultValid), .result(result),
    .resultCredit(resultCredit)
  );

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////
  task automatic failRun(input string what);
    $display("%s", what);
    $display("Result: FAILED");
    $fatal(1, "Simulation stopped on the first error");
  endtask

  task automatic nextCycle();
    @(posedge clk);
    #1;  // Drive phase
  endtask

  // Galois LFSR stepped once per bit taken
  function automatic logic [15:0] randBits(input int n);
    logic [15:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ 16'hB400) : (lfsrState >> 1);
      v = {v[14:0], lfsrState[0]};
    end
    return v;
  endfunction

  function automatic string showResult(input resultT r);
    return $sformatf("r%0d=%h z%b n%b w%b", r.dstReg, r.value, r.zero, r.neg, r.wrote);
  endfunction

  // Reference model applying one instruction in program order
  task automatic modelStep(input instrWordT w);
    logic [dataWidth-1:0] a;
    logic [dataWidth-1:0] b;
    logic [dataWidth-1:0] old;
    logic [dataWidth-1:0] v;
    logic                 isNop;
    resultT               r;
    a     = refRegs[w.rs];
    b     = refRegs[w.rt];
    old   = refRegs[w.rd];   // Byte loads merge into this
    isNop = 1'b0;
    case (w.opcode)
      opAdd: v = a + b;
      opSub: v = a - b;
      opAnd: v = a & b;
      opOr:  v = a | b;
      opXor: v = a ^ b;
      opSll: v = a << w.rt;
      opSrl: v = a >> w.rt;
      opSra: v = $signed(a) >>> w.rt;
      opLlb: v = {old[15:8], w.rs, w.rt};
      opLhb: v = {w.rs, w.rt, old[7:0]};
      default: begin
        v     = '0;
        isNop = 1'b1;  // Undefined codes write nothing
      end
    endcase
    r.dstReg = w.rd;
    r.value  = v;
    r.zero   = (v == '0);
    r.neg    = v[15];
    r.wrote  = !isNop && (w.rd != 4'd0);
    if (r.wrote) refRegs[w.rd] = v;
    expQ.push_back(r);
  endtask

  // Source side that sends only while it holds a credit
  task automatic sendInstr(input logic [3:0] opc, input logic [3:0] rd,
                           input logic [3:0] rs, input logic [3:0] rt);
    instrWordT w;
    int        waited;
    w      = '{opcode: opc, rd: rd, rs: rs, rt: rt};
    waited = 0;
    while (srcCredits == 0) begin
      instrValid = 1'b0;
      nextCycle();
      waited++;
      assert (waited < timeoutCycles)
        else failRun("Source waited too long for an instruction credit");
    end
    modelStep(w);
    srcCredits--;
    instrValid = 1'b1;
    instr      = w;
    nextCycle();
    instrValid = 1'b0;
  endtask

  task automatic loadReg(input logic [3:0] rd, input logic [15:0] value);
    sendInstr(opLlb, rd, value[7:4], value[3:0]);
    sendInstr(opLhb, rd, value[15:12], value[11:8]);  // Reads rd through the bypass
  endtask

  task automatic drainResults();
    int waited;
    waited = 0;
    while (expQ.size() != 0 || heldCredits != 0) begin
      nextCycle();
      waited++;
      assert (waited < timeoutCycles) else failRun("Results did not drain in time");
    end
    nextCycle();  // Last credit pulse reaches the core
  endtask

  //////////////////////////////////////////////////////////////////////
  // Clock, sink and result monitor
  //////////////////////////////////////////////////////////////////////
  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always begin
    @(posedge clk);
    if (instrCredit) srcCredits++;
    if (resultValid) begin
      assert (expQ.size() != 0) else failRun("Result arrived with nothing outstanding");
      assert (result == expQ[0])
        else failRun($sformatf("[ERROR] %s: expected %s actual %s", testName,
                               showResult(expQ[0]), showResult(result)));
      void'(expQ.pop_front());
      resultCount++;
      heldCredits++;
    end
    giveCredit = sinkOpen && (heldCredits > 0);  // At most one slot per cycle
    if (giveCredit) heldCredits--;
    #1;
    resultCredit = giveCredit;
  end

  //////////////////////////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////////////////////////
  task automatic testReset();
    testName = "reset";
    assert (resultValid == 1'b0)
      else failRun($sformatf("[ERROR] %s: expected resultValid %b actual %b",
                             testName, 1'b0, resultValid));
    assert (instrCredit == 1'b0)
      else failRun($sformatf("[ERROR] %s: expected instrCredit %b actual %b",
                             testName, 1'b0, instrCredit));
    sendInstr(opAdd, 4'd1, 4'd0, 4'd0);  // r0 + r0 gives zero
    drainResults();
  endtask

  task automatic testAlu();
    testName = "alu";
    for (int r = 1; r < 9; r++) begin
      loadReg(4'(r), randBits(16));
    end
    for (int round = 0; round < 3; round++) begin
      for (int op = 0; op < 8; op++) begin
        sendInstr(4'(op), 4'(1 + randBits(3)), 4'(randBits(4)), 4'(randBits(4)));
      end
    end
    drainResults();
  endtask

  task automatic testChain();
    logic [3:0] prev;
    logic [3:0] dst;
    testName = "chain";
    loadReg(4'd1, randBits(16));
    prev = 4'd1;
    for (int i = 0; i < 16; i++) begin
      dst = 4'(2 + (i % 6));
      sendInstr(4'(randBits(3)), dst, prev, 4'(randBits(4)));  // Reads last result
      prev = dst;
    end
    drainResults();
  endtask

  task automatic testZero();
    testName = "zero";
    sendInstr(opAdd, 4'd0, 4'd1, 4'd2);
    sendInstr(opLlb, 4'd0, 4'hF, 4'hF);
    sendInstr(opLhb, 4'd0, 4'hA, 4'h5);
    sendInstr(opOr, 4'd3, 4'd0, 4'd0);   // r0 must still read zero
    sendInstr(opAdd, 4'd4, 4'd0, 4'd5);
    drainResults();
  endtask

  task automatic testBackPressure();
    int startCount;
    int waited;
    testName   = "backpressure";
    startCount = resultCount;
    sinkOpen   = 1'b0;
    fork
      begin
        for (int i = 0; i < 8; i++) begin
          sendInstr(4'(randBits(3)), 4'(1 + randBits(3)), 4'(randBits(4)), 4'(randBits(4)));
        end
      end
      begin
        waited = 0;
        while (srcCredits != 0) begin
          nextCycle();
          waited++;
          assert (waited < timeoutCycles) else failRun("Source never ran out of credits");
        end
        repeat (10) nextCycle();  // Core stays blocked
        assert (resultCount - startCount <= outCredits)
          else failRun($sformatf("[ERROR] %s: expected at most %0d results actual %0d",
                                 testName, outCredits, resultCount - startCount));
        assert (srcCredits == 0)
          else failRun($sformatf("[ERROR] %s: expected source credits %0d actual %0d",
                                 testName, 0, srcCredits));
        sinkOpen = 1'b1;
      end
    join
    drainResults();
    // Every popped word hands back exactly one credit
    assert (srcCredits == inCredits)
      else failRun($sformatf("[ERROR] %s: expected source credits %0d actual %0d",
                             testName, inCredits, srcCredits));
  endtask

  task automatic testUndefined();
    logic [3:0] dst;
    testName = "undefined";
    for (int code = 10; code < 16; code++) begin
      dst = 4'(1 + randBits(3));
      sendInstr(4'(code), dst, 4'(randBits(4)), 4'(randBits(4)));
      sendInstr(opOr, 4'd9, dst, 4'd0);  // Old value of dst still there
    end
    drainResults();
  endtask

  initial begin
    rst          = 1'b1;
    instrValid   = 1'b0;
    instr        = '0;
    resultCredit = 1'b0;
    sinkOpen     = 1'b1;
    srcCredits   = inCredits;
    heldCredits  = 0;
    resultCount  = 0;
    lfsrState    = 16'd66;
    testName     = "init";
    for (int i = 0; i < numRegs; i++) begin
      refRegs[i] = '0;
    end
    repeat (10) @(posedge clk);
    #1;
    rst = 1'b0;
    nextCycle();
    testReset();
    testAlu();
    testChain();
    testZero();
    testBackPressure();
    testUndefined();
    if (expQ.size() == 0) begin
      $display("Result: PASSED");
      $finish;
    end else begin
      failRun("Expected results still outstanding at the end");
    end
  end

endmodule

`default_nettype wire

// File: filelist.f
src/cpuPkg.sv
src/instrDecoder.sv
src/registerFile.sv
src/aluUnit.sv
src/issueControl.sv
src/execCore.sv
verif/execCore_chk.sv
verif/execCoreTb.sv

// File: runSim.sh
#!/bin/sh
# Build and run the execute core testbench with Verilator
# Fails on a broken build, a crashed run or a failure line in the log

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
  echo "Cannot enter the project root"
  exit 1
fi

buildDir=obj_dir
logFile=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module execCoreTb --Mdir "$buildDir" -f filelist.f
if [ $? -ne 0 ]; then
  echo "Build failed"
  exit 1
fi

"./$buildDir/VexecCoreTb" > "$logFile" 2>&1
runStatus=$?
cat "$logFile"

if grep -q "Result: FAILED" "$logFile"; then
  echo "Simulation reported a failure"
  exit 1
fi
if [ $runStatus -ne 0 ]; then
  echo "Simulation exited with status $runStatus"
  exit 1
fi

echo "Simulation finished cleanly"
exit 0
